// ==== logic/sba_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Addresses are 32 bits wide; only 32-bit and 64-bit accesses exist
//////////////////////////////////////////////////////////////////////

package sba_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  typedef logic [31:0] sb_addr_t;
  typedef logic [63:0] sb_data_t;
  typedef logic [6:0]  dmi_addr_t;
  typedef logic [31:0] dmi_data_t;
  typedef logic [2:0]  sb_size_t;
  typedef logic [2:0]  sb_err_t;

  // Legal access sizes
  localparam sb_size_t SbSize32 = 3'd2;
  localparam sb_size_t SbSize64 = 3'd3;

  // Error codes as reported in the SBCS error field
  localparam sb_err_t SbErrNone  = 3'd0;
  localparam sb_err_t SbErrAddr  = 3'd2;
  localparam sb_err_t SbErrAlign = 3'd3;
  localparam sb_err_t SbErrSize  = 3'd4;
  localparam sb_err_t SbErrBusy  = 3'd7;

  //////////////////////////////////////////////////////////////////////
  // DMI register addresses
  //////////////////////////////////////////////////////////////////////

  localparam dmi_addr_t DmiSbcs       = 7'h38;
  localparam dmi_addr_t DmiSbAddress0 = 7'h39;
  localparam dmi_addr_t DmiSbData0    = 7'h3C;
  localparam dmi_addr_t DmiSbData1    = 7'h3D;

  //////////////////////////////////////////////////////////////////////
  // System bus address map
  //////////////////////////////////////////////////////////////////////

  localparam sb_addr_t SpmBase = 32'h0100_0000;
  localparam sb_addr_t CsrBase = 32'h0300_0000;

  // Byte offsets of the boot scratch registers
  localparam logic [3:0] CsrEntryOffset = 4'h4;
  localparam logic [3:0] CsrTokenOffset = 4'h8;
  localparam logic [3:0] CsrEocOffset   = 4'hC;

endpackage

// ==== logic/dmi_regs.sv ====
//////////////////////////////////////////////////////////////////////
// Register writes are ignored while busy; the debugger must poll sbbusy
// Reads return one cycle after the request, unknown addresses read zero
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module dmi_regs (
  input  logic               clk_sys,
  input  logic               reset_i,
  input  logic               dmi_req_i,
  input  logic               dmi_we_i,
  input  sba_pkg::dmi_addr_t dmi_addr_i,
  input  sba_pkg::dmi_data_t dmi_wdata_i,
  input  logic               acc_done_i,
  input  sba_pkg::sb_err_t   acc_err_i,
  input  sba_pkg::sb_data_t  acc_rdata_i,
  output sba_pkg::dmi_data_t dmi_rdata_o,
  output logic               dmi_rvalid_o,
  output logic               acc_start_o,
  output logic               acc_we_o,
  output sba_pkg::sb_addr_t  acc_addr_o,
  output sba_pkg::sb_size_t  acc_size_o,
  output sba_pkg::sb_data_t  acc_wdata_o
);
  import sba_pkg::*;

  // SBCS bit positions
  localparam int SbcsBusyBit    = 21;
  localparam int SbcsRoaBit     = 20;
  localparam int SbcsAccessLsb  = 17;
  localparam int SbcsAutoincBit = 16;
  localparam int SbcsRodBit     = 15;
  localparam int SbcsErrLsb     = 12;

  logic      roa_q, rod_q, autoinc_q, busy_q;
  sb_size_t  access_q;
  sb_err_t   err_q, err_keep, err_new;
  sb_addr_t  addr_q;
  dmi_data_t data0_q, data1_q;
  logic      pend_we_q, pend_wide_q;
  logic      rvalid_q;
  dmi_data_t rdata_q, sbcs_value;
  logic      wr_sbcs, wr_addr, wr_data0, wr_data1, rd_data0;
  logic      trigger, busy_err, done_ok;

  //////////////////////////////////////////////////////////////////////
  // Request decode and access start
  //////////////////////////////////////////////////////////////////////

  assign wr_sbcs  = dmi_req_i && dmi_we_i && (dmi_addr_i == DmiSbcs);
  assign wr_addr  = dmi_req_i && dmi_we_i && (dmi_addr_i == DmiSbAddress0);
  assign wr_data0 = dmi_req_i && dmi_we_i && (dmi_addr_i == DmiSbData0);
  assign wr_data1 = dmi_req_i && dmi_we_i && (dmi_addr_i == DmiSbData1);
  assign rd_data0 = dmi_req_i && !dmi_we_i && (dmi_addr_i == DmiSbData0);

  assign trigger  = wr_data0 || (wr_addr && roa_q) || (rd_data0 && rod_q);
  assign busy_err = trigger && busy_q;
  assign done_ok  = acc_done_i && (acc_err_i == SbErrNone);

  assign acc_start_o = trigger && !busy_q;
  assign acc_we_o    = wr_data0;
  assign acc_size_o  = access_q;
  // Forward the value written this cycle so the access sees it at once
  assign acc_addr_o  = wr_addr ? dmi_wdata_i : addr_q;
  assign acc_wdata_o = {data1_q, wr_data0 ? dmi_wdata_i : data0_q};

  // Sticky error, software clears it by writing ones
  always_comb begin
    err_keep = wr_sbcs ? (err_q & ~dmi_wdata_i[SbcsErrLsb +: 3]) : err_q;
    if (acc_done_i && acc_err_i != SbErrNone) begin
      err_new = acc_err_i;
    end else if (busy_err) begin
      err_new = SbErrBusy;
    end else begin
      err_new = SbErrNone;
    end
  end

  always_comb begin
    sbcs_value                        = '0;
    sbcs_value[SbcsBusyBit]           = busy_q;
    sbcs_value[SbcsRoaBit]            = roa_q;
    sbcs_value[SbcsAccessLsb +: 3]    = access_q;
    sbcs_value[SbcsAutoincBit]        = autoinc_q;
    sbcs_value[SbcsRodBit]            = rod_q;
    sbcs_value[SbcsErrLsb +: 3]       = err_q;
  end

  //////////////////////////////////////////////////////////////////////
  // Control state
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys) begin
    if (reset_i) begin
      roa_q     <= 1'b0;
      rod_q     <= 1'b0;
      autoinc_q <= 1'b0;
      access_q  <= '0;
      busy_q    <= 1'b0;
      err_q     <= SbErrNone;
      rvalid_q  <= 1'b0;
    end else begin
      rvalid_q <= dmi_req_i && !dmi_we_i;
      if (wr_sbcs) begin
        roa_q     <= dmi_wdata_i[SbcsRoaBit];
        rod_q     <= dmi_wdata_i[SbcsRodBit];
        autoinc_q <= dmi_wdata_i[SbcsAutoincBit];
        access_q  <= dmi_wdata_i[SbcsAccessLsb +: 3];
      end
      if (acc_start_o) begin
        busy_q <= 1'b1;
      end else if (acc_done_i) begin
        busy_q <= 1'b0;
      end
      if (err_keep == SbErrNone && err_new != SbErrNone) begin
        err_q <= err_new;
      end else begin
        err_q <= err_keep;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Address, data and read return
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys) begin
    if (acc_start_o) begin
      pend_we_q   <= acc_we_o;
      pend_wide_q <= (access_q == SbSize64);
    end
    if (wr_addr && !busy_q) begin
      addr_q <= dmi_wdata_i;
    end else if (done_ok && autoinc_q) begin
      addr_q <= addr_q + (pend_wide_q ? 32'd8 : 32'd4);
    end
    if (wr_data0 && !busy_q) begin
      data0_q <= dmi_wdata_i;
    end else if (done_ok && !pend_we_q) begin
      data0_q <= acc_rdata_i[31:0];
    end
    if (wr_data1 && !busy_q) begin
      data1_q <= dmi_wdata_i;
    end else if (done_ok && !pend_we_q && pend_wide_q) begin
      data1_q <= acc_rdata_i[63:32];
    end
    // Read-on-data returns the value held before the new access
    case (dmi_addr_i)
      DmiSbcs:       rdata_q <= sbcs_value;
      DmiSbAddress0: rdata_q <= addr_q;
      DmiSbData0:    rdata_q <= data0_q;
      DmiSbData1:    rdata_q <= data1_q;
      default:       rdata_q <= '0;
    endcase
  end

  assign dmi_rvalid_o = rvalid_q;
  assign dmi_rdata_o  = rdata_q;

endmodule

// ==== logic/sb_master.sv ====
//////////////////////////////////////////////////////////////////////
// Fixed latency: done follows start by two cycles, never checks busy
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module sb_master #(
  parameter int MemWordsLog2 = 10
) (
  input  logic                    clk_sys,
  input  logic                    reset_i,
  input  logic                    acc_start_i,
  input  logic                    acc_we_i,
  input  sba_pkg::sb_addr_t       acc_addr_i,
  input  sba_pkg::sb_size_t       acc_size_i,
  input  sba_pkg::sb_data_t       acc_wdata_i,
  input  sba_pkg::sb_data_t       mem_rdata_i,
  input  sba_pkg::dmi_data_t      csr_rdata_i,
  output logic                    acc_done_o,
  output sba_pkg::sb_err_t        acc_err_o,
  output sba_pkg::sb_data_t       acc_rdata_o,
  output logic                    mem_sel_o,
  output logic                    mem_we_o,
  output logic [MemWordsLog2-1:0] mem_index_o,
  output sba_pkg::sb_data_t       mem_wdata_o,
  output logic [7:0]              mem_be_o,
  output logic                    csr_sel_o,
  output logic                    csr_we_o,
  output logic [3:0]              csr_offset_o,
  output sba_pkg::dmi_data_t      csr_wdata_o
);
  import sba_pkg::*;

  typedef enum logic [1:0] {StIdle, StIssue, StRespond} state_e;

  state_e                  state_q;
  sb_addr_t                spm_offset;
  logic                    wide, size_ok, aligned, in_spm, in_csr;
  sb_err_t                 err_d, err_q;
  logic                    to_mem_q, we_q, hi_lane_q;
  logic [MemWordsLog2-1:0] index_q;
  logic [3:0]              offset_q;
  sb_data_t                wdata_q;
  logic [7:0]              be_q;
  dmi_data_t               csr_rdata_q;

  //////////////////////////////////////////////////////////////////////
  // Address decode and checks
  //////////////////////////////////////////////////////////////////////

  assign wide       = (acc_size_i == SbSize64);
  assign size_ok    = (acc_size_i == SbSize32) || wide;
  assign aligned    = wide ? (acc_addr_i[2:0] == 3'd0) : (acc_addr_i[1:0] == 2'd0);
  assign spm_offset = acc_addr_i - SpmBase;
  assign in_spm     = (spm_offset >> (MemWordsLog2 + 3)) == '0;
  assign in_csr     = (acc_addr_i[31:4] == CsrBase[31:4]) &&
                      (acc_addr_i[3:0] inside {CsrEntryOffset, CsrTokenOffset, CsrEocOffset});

  always_comb begin
    if (!size_ok) begin
      err_d = SbErrSize;
    end else if (!aligned) begin
      err_d = SbErrAlign;
    end else if (!in_spm && !in_csr) begin
      err_d = SbErrAddr;
    end else if (in_csr && wide) begin
      // Boot registers are 32 bits only
      err_d = SbErrSize;
    end else begin
      err_d = SbErrNone;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys) begin
    if (reset_i) begin
      state_q <= StIdle;
    end else begin
      case (state_q)
        StIdle:    if (acc_start_i) state_q <= StIssue;
        StIssue:   state_q <= StRespond;
        default:   state_q <= StIdle;
      endcase
    end
  end

  always_ff @(posedge clk_sys) begin
    if (state_q == StIdle && acc_start_i) begin
      err_q     <= err_d;
      to_mem_q  <= in_spm;
      we_q      <= acc_we_i;
      hi_lane_q <= acc_addr_i[2] && !wide;
      index_q   <= spm_offset[MemWordsLog2+2:3];
      offset_q  <= acc_addr_i[3:0];
      wdata_q   <= wide ? acc_wdata_i : {2{acc_wdata_i[31:0]}};
      be_q      <= wide ? 8'hFF : (acc_addr_i[2] ? 8'hF0 : 8'h0F);
    end
    if (csr_sel_o) begin
      csr_rdata_q <= csr_rdata_i;
    end
  end

  // Targets are only touched by error-free accesses
  assign mem_sel_o    = (state_q == StIssue) && to_mem_q && (err_q == SbErrNone);
  assign csr_sel_o    = (state_q == StIssue) && !to_mem_q && (err_q == SbErrNone);
  assign mem_we_o     = we_q;
  assign mem_index_o  = index_q;
  assign mem_wdata_o  = wdata_q;
  assign mem_be_o     = be_q;
  assign csr_we_o     = we_q;
  assign csr_offset_o = offset_q;
  assign csr_wdata_o  = wdata_q[31:0];

  assign acc_done_o  = (state_q == StRespond);
  assign acc_err_o   = err_q;
  assign acc_rdata_o = !to_mem_q ? {32'd0, csr_rdata_q} :
                       hi_lane_q ? {32'd0, mem_rdata_i[63:32]} : mem_rdata_i;

endmodule

// ==== logic/spm_mem.sv ====
//////////////////////////////////////////////////////////////////////
// Contents start undefined; read data is valid one cycle after sel_i
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module spm_mem #(
  parameter int MemWordsLog2 = 10
) (
  input  logic                    clk_sys,
  input  logic                    sel_i,
  input  logic                    we_i,
  input  logic [MemWordsLog2-1:0] index_i,
  input  sba_pkg::sb_data_t       wdata_i,
  input  logic [7:0]              be_i,
  output sba_pkg::sb_data_t       rdata_o
);
  import sba_pkg::*;

  sb_data_t mem [2**MemWordsLog2];
  sb_data_t rdata_q;

  always_ff @(posedge clk_sys) begin
    if (sel_i) begin
      if (we_i) begin
        for (int b = 0; b < 8; b++) begin
          if (be_i[b]) begin
            mem[index_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
      // Old contents on a write cycle
      rdata_q <= mem[index_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== logic/boot_csr.sv ====
//////////////////////////////////////////////////////////////////////
// Offset 0 and unknown offsets read zero and ignore writes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module boot_csr (
  input  logic               clk_sys,
  input  logic               reset_i,
  input  logic               sel_i,
  input  logic               we_i,
  input  logic [3:0]         offset_i,
  input  sba_pkg::dmi_data_t wdata_i,
  output sba_pkg::dmi_data_t rdata_o,
  output sba_pkg::sb_addr_t  boot_entry_o,
  output logic               boot_go_o,
  output logic               eoc_o,
  output logic [30:0]        exit_code_o
);
  import sba_pkg::*;

  sb_addr_t  entry_q;
  dmi_data_t token_q;
  dmi_data_t eoc_q;
  logic      wr;

  assign wr = sel_i && we_i;

  // Start token and end-of-computation word gate the outside world
  always_ff @(posedge clk_sys) begin
    if (reset_i) begin
      token_q <= '0;
      eoc_q   <= '0;
    end else if (wr) begin
      if (offset_i == CsrTokenOffset) begin
        token_q <= wdata_i;
      end
      if (offset_i == CsrEocOffset) begin
        eoc_q <= wdata_i;
      end
    end
  end

  always_ff @(posedge clk_sys) begin
    if (wr && offset_i == CsrEntryOffset) begin
      entry_q <= wdata_i;
    end
  end

  always_comb begin
    case (offset_i)
      CsrEntryOffset: rdata_o = entry_q;
      CsrTokenOffset: rdata_o = token_q;
      CsrEocOffset:   rdata_o = eoc_q;
      default:        rdata_o = '0;
    endcase
  end

  assign boot_entry_o = entry_q;
  assign boot_go_o    = token_q[0];
  // Bit 0 flags completion, the rest is the exit code
  assign eoc_o        = eoc_q[0];
  assign exit_code_o  = eoc_q[31:1];

endmodule

// ==== logic/sba_top.sv ====
//////////////////////////////////////////////////////////////////////
// DMI is driven directly; no JTAG transport in front of it
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module sba_top #(
  parameter int MemWordsLog2 = 10
) (
  input  logic               clk_sys,
  input  logic               reset_i,
  input  logic               dmi_req_i,
  input  logic               dmi_we_i,
  input  sba_pkg::dmi_addr_t dmi_addr_i,
  input  sba_pkg::dmi_data_t dmi_wdata_i,
  output sba_pkg::dmi_data_t dmi_rdata_o,
  output logic               dmi_rvalid_o,
  output sba_pkg::sb_addr_t  boot_entry_o,
  output logic               boot_go_o,
  output logic               eoc_o,
  output logic [30:0]        exit_code_o
);
  import sba_pkg::*;

  logic                    acc_start, acc_we, acc_done;
  sb_addr_t                acc_addr;
  sb_size_t                acc_size;
  sb_data_t                acc_wdata, acc_rdata;
  sb_err_t                 acc_err;
  logic                    mem_sel, mem_we;
  logic [MemWordsLog2-1:0] mem_index;
  sb_data_t                mem_wdata, mem_rdata;
  logic [7:0]              mem_be;
  logic                    csr_sel, csr_we;
  logic [3:0]              csr_offset;
  dmi_data_t               csr_wdata, csr_rdata;

  dmi_regs u_dmi_regs (
    .clk_sys      (clk_sys),
    .reset_i      (reset_i),
    .dmi_req_i    (dmi_req_i),
    .dmi_we_i     (dmi_we_i),
    .dmi_addr_i   (dmi_addr_i),
    .dmi_wdata_i  (dmi_wdata_i),
    .acc_done_i   (acc_done),
    .acc_err_i    (acc_err),
    .acc_rdata_i  (acc_rdata),
    .dmi_rdata_o  (dmi_rdata_o),
    .dmi_rvalid_o (dmi_rvalid_o),
    .acc_start_o  (acc_start),
    .acc_we_o     (acc_we),
    .acc_addr_o   (acc_addr),
    .acc_size_o   (acc_size),
    .acc_wdata_o  (acc_wdata)
  );

  sb_master #(
    .MemWordsLog2 (MemWordsLog2)
  ) u_sb_master (
    .clk_sys      (clk_sys),
    .reset_i      (reset_i),
    .acc_start_i  (acc_start),
    .acc_we_i     (acc_we),
    .acc_addr_i   (acc_addr),
    .acc_size_i   (acc_size),
    .acc_wdata_i  (acc_wdata),
    .mem_rdata_i  (mem_rdata),
    .csr_rdata_i  (csr_rdata),
    .acc_done_o   (acc_done),
    .acc_err_o    (acc_err),
    .acc_rdata_o  (acc_rdata),
    .mem_sel_o    (mem_sel),
    .mem_we_o     (mem_we),
    .mem_index_o  (mem_index),
    .mem_wdata_o  (mem_wdata),
    .mem_be_o     (mem_be),
    .csr_sel_o    (csr_sel),
    .csr_we_o     (csr_we),
    .csr_offset_o (csr_offset),
    .csr_wdata_o  (csr_wdata)
  );

  spm_mem #(
    .MemWordsLog2 (MemWordsLog2)
  ) u_spm_mem (
    .clk_sys (clk_sys),
    .sel_i   (mem_sel),
    .we_i    (mem_we),
    .index_i (mem_index),
    .wdata_i (mem_wdata),
    .be_i    (mem_be),
    .rdata_o (mem_rdata)
  );

  boot_csr u_boot_csr (
    .clk_sys      (clk_sys),
    .reset_i      (reset_i),
    .sel_i        (csr_sel),
    .we_i         (csr_we),
    .offset_i     (csr_offset),
    .wdata_i      (csr_wdata),
    .rdata_o      (csr_rdata),
    .boot_entry_o (boot_entry_o),
    .boot_go_o    (boot_go_o),
    .eoc_o        (eoc_o),
    .exit_code_o  (exit_code_o)
  );

endmodule

// ==== testbench/sba_assert.sv ====
//////////////////////////////////////////////////////////////////////
// Watches the top level only; memory contents are not checked here
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module sba_assert (
  input logic               clk_sys,
  input logic               reset_i,
  input logic               dmi_req_i,
  input logic               dmi_we_i,
  input sba_pkg::dmi_addr_t dmi_addr_i,
  input sba_pkg::dmi_data_t dmi_rdata_o,
  input logic               dmi_rvalid_o,
  input logic               boot_go_o,
  input logic               eoc_o,
  input logic               acc_start,
  input logic               acc_done,
  input sba_pkg::sb_err_t   acc_err,
  input logic               mem_sel,
  input logic               csr_sel
);
  import sba_pkg::*;

  logic rd_req, rd_unknown;

  assign rd_req     = dmi_req_i && !dmi_we_i;
  assign rd_unknown = rd_req &&
                      !(dmi_addr_i inside {DmiSbcs, DmiSbAddress0, DmiSbData0, DmiSbData1});

  // Read valid follows each read request by one cycle and never otherwise
  assert property (@(posedge clk_sys) disable iff (reset_i) rd_req |=> dmi_rvalid_o)
    else $error("read valid missing one cycle after a read request");
  assert property (@(posedge clk_sys) disable iff (reset_i) !rd_req |=> !dmi_rvalid_o)
    else $error("read valid without a read request");
  assert property (@(posedge clk_sys) disable iff (reset_i) rd_unknown |=> dmi_rdata_o == '0)
    else $error("unknown register did not read as zero");

  // Fixed two cycle access
  assert property (@(posedge clk_sys) disable iff (reset_i) acc_start |-> ##2 acc_done)
    else $error("access done did not follow start by two cycles");
  assert property (@(posedge clk_sys) disable iff (reset_i) acc_done |-> $past(acc_start, 2))
    else $error("access done without a start two cycles earlier");
  assert property (@(posedge clk_sys) disable iff (reset_i)
                   acc_start |=> !acc_start ##1 !acc_start)
    else $error("new access started while busy");

  // Failed accesses leave every target alone
  assert property (@(posedge clk_sys) disable iff (reset_i)
                   (acc_done && acc_err != SbErrNone) |-> $past(!mem_sel && !csr_sel))
    else $error("access with an error selected a target");

  assert property (@(posedge clk_sys) reset_i |=> !dmi_rvalid_o && !boot_go_o && !eoc_o)
    else $error("control outputs active after reset");

endmodule

bind sba_top sba_assert u_sba_assert (
  .clk_sys      (clk_sys),
  .reset_i      (reset_i),
  .dmi_req_i    (dmi_req_i),
  .dmi_we_i     (dmi_we_i),
  .dmi_addr_i   (dmi_addr_i),
  .dmi_rdata_o  (dmi_rdata_o),
  .dmi_rvalid_o (dmi_rvalid_o),
  .boot_go_o    (boot_go_o),
  .eoc_o        (eoc_o),
  .acc_start    (acc_start),
  .acc_done     (acc_done),
  .acc_err      (acc_err),
  .mem_sel      (mem_sel),
  .csr_sel      (csr_sel)
);

// ==== testbench/tb_sba.sv ====
//////////////////////////////////////////////////////////////////////
// Runs with a 64-word memory; timing rules are left to the bound checks
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_sba;
  import sba_pkg::*;

  // SBCS fields as seen by the debugger
  localparam int SbcsBusyBit    = 21;
  localparam int SbcsRoaBit     = 20;
  localparam int SbcsAccessLsb  = 17;
  localparam int SbcsAutoincBit = 16;
  localparam int SbcsRodBit     = 15;
  localparam int SbcsErrLsb     = 12;
  localparam dmi_data_t ErrClearMask = 32'h0000_7000;
  localparam int PollLimit = 20;

  logic        clk_sys = 1'b0;
  logic        reset_i;
  logic        dmi_req_i;
  logic        dmi_we_i;
  dmi_addr_t   dmi_addr_i;
  dmi_data_t   dmi_wdata_i;
  dmi_data_t   dmi_rdata_o;
  logic        dmi_rvalid_o;
  sb_addr_t    boot_entry_o;
  logic        boot_go_o;
  logic        eoc_o;
  logic [30:0] exit_code_o;

  // Expected memory contents
  sb_data_t model [64];

  sba_top #(
    .MemWordsLog2 (6)
  ) DUT (
    .clk_sys      (clk_sys),
    .reset_i      (reset_i),
    .dmi_req_i    (dmi_req_i),
    .dmi_we_i     (dmi_we_i),
    .dmi_addr_i   (dmi_addr_i),
    .dmi_wdata_i  (dmi_wdata_i),
    .dmi_rdata_o  (dmi_rdata_o),
    .dmi_rvalid_o (dmi_rvalid_o),
    .boot_entry_o (boot_entry_o),
    .boot_go_o    (boot_go_o),
    .eoc_o        (eoc_o),
    .exit_code_o  (exit_code_o)
  );

  always #50 clk_sys = ~clk_sys;

  //////////////////////////////////////////////////////////////////////
  // Reporting
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      abort_run($sformatf("** Error: %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  function automatic dmi_data_t sbcs_word(input logic roa, input logic rod,
                                          input logic autoinc, input sb_size_t size);
    dmi_data_t w;
    w = '0;
    w[SbcsRoaBit] = roa;
    w[SbcsRodBit] = rod;
    w[SbcsAutoincBit] = autoinc;
    w[SbcsAccessLsb +: 3] = size;
    return w;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // DMI driver
  //////////////////////////////////////////////////////////////////////

  task automatic dmi_write(input dmi_addr_t addr, input dmi_data_t data);
    @(posedge clk_sys);
    dmi_req_i   <= 1'b1;
    dmi_we_i    <= 1'b1;
    dmi_addr_i  <= addr;
    dmi_wdata_i <= data;
    @(posedge clk_sys);
    dmi_req_i <= 1'b0;
    dmi_we_i  <= 1'b0;
  endtask

  // Two SBData0 writes on consecutive cycles
  task automatic dmi_write_twice(input dmi_data_t first, input dmi_data_t second);
    @(posedge clk_sys);
    dmi_req_i   <= 1'b1;
    dmi_we_i    <= 1'b1;
    dmi_addr_i  <= DmiSbData0;
    dmi_wdata_i <= first;
    @(posedge clk_sys);
    dmi_wdata_i <= second;
    @(posedge clk_sys);
    dmi_req_i <= 1'b0;
    dmi_we_i  <= 1'b0;
  endtask

  task automatic dmi_read(input dmi_addr_t addr, output dmi_data_t data);
    @(posedge clk_sys);
    dmi_req_i  <= 1'b1;
    dmi_we_i   <= 1'b0;
    dmi_addr_i <= addr;
    @(posedge clk_sys);
    dmi_req_i <= 1'b0;
    @(negedge clk_sys);
    if (dmi_rvalid_o !== 1'b1) begin
      abort_run("DMI read data was not valid one cycle after the request");
    end
    data = dmi_rdata_o;
  endtask

  task automatic check_read(input string name, input dmi_addr_t addr, input dmi_data_t exp);
    dmi_data_t got;
    dmi_read(addr, got);
    check_value(name, 64'(exp), 64'(got));
  endtask

  task automatic wait_idle(input string name);
    dmi_data_t v;
    int tries;
    tries = 0;
    do begin
      dmi_read(DmiSbcs, v);
      tries++;
    end while (v[SbcsBusyBit] && tries < PollLimit);
    if (v[SbcsBusyBit]) begin
      abort_run($sformatf("%s: busy never cleared after %0d polls", name, tries));
    end
  endtask

  task automatic check_err(input string name, input sb_err_t exp);
    dmi_data_t v;
    dmi_read(DmiSbcs, v);
    check_value(name, 64'(exp), 64'(v[SbcsErrLsb +: 3]));
  endtask

  task automatic check_reset_state(input string name);
    check_value({name, " rvalid"}, 64'(0), 64'(dmi_rvalid_o));
    check_value({name, " go"}, 64'(0), 64'(boot_go_o));
    check_value({name, " eoc"}, 64'(0), 64'(eoc_o));
    check_read({name, " sbcs"}, DmiSbcs, 32'd0);
  endtask

  task automatic read_word_back(input string name, input int idx);
    dmi_write(DmiSbcs, sbcs_word(1'b1, 1'b0, 1'b0, SbSize64));
    dmi_write(DmiSbAddress0, SpmBase + 32'(idx * 8));
    wait_idle(name);
    check_read({name, " upper"}, DmiSbData1, model[idx][63:32]);
    check_read({name, " lower"}, DmiSbData0, model[idx][31:0]);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Scenarios
  //////////////////////////////////////////////////////////////////////

  task automatic preload_readback();
    dmi_write(DmiSbcs, sbcs_word(1'b0, 1'b0, 1'b1, SbSize64));
    dmi_write(DmiSbAddress0, SpmBase);
    for (int i = 0; i < 20; i++) begin
      model[i] = {$urandom, $urandom};
      dmi_write(DmiSbData1, model[i][63:32]);
      dmi_write(DmiSbData0, model[i][31:0]);
      wait_idle("preload");
    end
    check_read("preload address", DmiSbAddress0, SpmBase + 32'd160);
    // Read-on-address fetches word 0, each SBData0 read fetches the next
    dmi_write(DmiSbcs, sbcs_word(1'b1, 1'b1, 1'b1, SbSize64));
    dmi_write(DmiSbAddress0, SpmBase);
    wait_idle("readback start");
    for (int i = 0; i < 20; i++) begin
      check_read($sformatf("readback word %0d upper", i), DmiSbData1, model[i][63:32]);
      check_read($sformatf("readback word %0d lower", i), DmiSbData0, model[i][31:0]);
      wait_idle("readback");
    end
  endtask

  task automatic lane_write();
    dmi_data_t lane;
    lane = $urandom;
    dmi_write(DmiSbcs, sbcs_word(1'b0, 1'b0, 1'b0, SbSize32));
    dmi_write(DmiSbAddress0, SpmBase + 32'd28);
    dmi_write(DmiSbData0, lane);
    wait_idle("lane write");
    model[3][63:32] = lane;
    dmi_write(DmiSbcs, sbcs_word(1'b1, 1'b0, 1'b0, SbSize32));
    dmi_write(DmiSbAddress0, SpmBase + 32'd28);
    wait_idle("lane read");
    check_read("lane read 32", DmiSbData0, lane);
    read_word_back("lane word", 3);
  endtask

  task automatic boot_handover();
    sb_addr_t entry;
    logic [30:0] code;
    entry = $urandom & 32'hFFFF_FFFC;
    code = 31'($urandom);
    check_value("go before token", 64'(0), 64'(boot_go_o));
    dmi_write(DmiSbcs, sbcs_word(1'b0, 1'b0, 1'b0, SbSize32));
    dmi_write(DmiSbAddress0, CsrBase + 32'(CsrEntryOffset));
    dmi_write(DmiSbData0, entry);
    wait_idle("entry write");
    check_value("boot entry", 64'(entry), 64'(boot_entry_o));
    dmi_write(DmiSbAddress0, CsrBase + 32'(CsrTokenOffset));
    dmi_write(DmiSbData0, 32'd1);
    wait_idle("token write");
    check_value("boot go", 64'(1), 64'(boot_go_o));
    check_value("eoc before end", 64'(0), 64'(eoc_o));
    dmi_write(DmiSbAddress0, CsrBase + 32'(CsrEocOffset));
    dmi_write(DmiSbData0, {code, 1'b1});
    wait_idle("eoc write");
    check_value("eoc flag", 64'(1), 64'(eoc_o));
    check_value("exit code", 64'(code), 64'(exit_code_o));
    // Boot registers read back through the bus as well
    dmi_write(DmiSbcs, sbcs_word(1'b1, 1'b0, 1'b0, SbSize32));
    dmi_write(DmiSbAddress0, CsrBase + 32'(CsrEntryOffset));
    wait_idle("entry read");
    check_read("entry readback", DmiSbData0, entry);
  endtask

  task automatic bad_write(input string name, input dmi_data_t sbcs, input sb_addr_t addr,
                           input sb_err_t exp);
    dmi_write(DmiSbcs, sbcs);
    dmi_write(DmiSbAddress0, addr);
    dmi_write(DmiSbData0, 32'h5A5A_5A50);
    wait_idle(name);
    check_err(name, exp);
    check_read({name, " address kept"}, DmiSbAddress0, addr);
    dmi_write(DmiSbcs, sbcs | ErrClearMask);
    check_err({name, " cleared"}, SbErrNone);
  endtask

  task automatic error_codes();
    bad_write("unmapped", sbcs_word(1'b0, 1'b0, 1'b1, SbSize32), 32'h0200_0000, SbErrAddr);
    bad_write("boot 64", sbcs_word(1'b0, 1'b0, 1'b1, SbSize64),
              CsrBase + 32'(CsrTokenOffset), SbErrSize);
    check_value("token kept", 64'(1), 64'(boot_go_o));
    bad_write("size 1", sbcs_word(1'b0, 1'b0, 1'b1, 3'd1), SpmBase, SbErrSize);
    bad_write("misaligned", sbcs_word(1'b0, 1'b0, 1'b1, SbSize32), SpmBase + 32'd2,
              SbErrAlign);
    read_word_back("word 0 kept", 0);
  endtask

  task automatic busy_collision();
    dmi_data_t hi;
    dmi_data_t first;
    hi = $urandom;
    first = $urandom;
    dmi_write(DmiSbcs, sbcs_word(1'b0, 1'b0, 1'b0, SbSize64));
    dmi_write(DmiSbAddress0, SpmBase + 32'd240);
    dmi_write(DmiSbData1, hi);
    dmi_write_twice(first, ~first);
    wait_idle("busy write");
    check_err("busy error", SbErrBusy);
    dmi_write(DmiSbcs, sbcs_word(1'b0, 1'b0, 1'b0, SbSize64) | ErrClearMask);
    check_err("busy cleared", SbErrNone);
    model[30] = {hi, first};
    read_word_back("busy word", 30);
  endtask

  // Every SBCS field, both boot flags and a read request are live at reset
  task automatic reset_with_state();
    dmi_write(DmiSbcs, sbcs_word(1'b1, 1'b1, 1'b1, 3'd1));
    dmi_write(DmiSbAddress0, SpmBase);
    wait_idle("reset setup");
    check_err("reset setup", SbErrSize);
    @(posedge clk_sys);
    reset_i    <= 1'b1;
    dmi_req_i  <= 1'b1;
    dmi_we_i   <= 1'b0;
    dmi_addr_i <= DmiSbcs;
    @(posedge clk_sys);
    dmi_req_i <= 1'b0;
    repeat (3) @(posedge clk_sys);
    reset_i <= 1'b0;
    @(negedge clk_sys);
    check_reset_state("second reset");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h63cc400f));
    reset_i     = 1'b1;
    dmi_req_i   = 1'b0;
    dmi_we_i    = 1'b0;
    dmi_addr_i  = '0;
    dmi_wdata_i = '0;
    repeat (4) @(posedge clk_sys);
    reset_i <= 1'b0;
    @(negedge clk_sys);
    check_reset_state("reset");
    check_read("unknown register", 7'h10, 32'd0);
    preload_readback();
    lane_write();
    boot_handover();
    error_codes();
    busy_collision();
    reset_with_state();
    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== compile.f ====
logic/sba_pkg.sv
logic/dmi_regs.sv
logic/sb_master.sv
logic/spm_mem.sv
logic/boot_csr.sv
logic/sba_top.sv
testbench/sba_assert.sv
testbench/tb_sba.sv

// ==== Makefile ====
# Verilator build and run of the system bus access testbench

VERILATOR ?= verilator
TOP       ?= tb_sba
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
PASS_MSG  := Done: no errors

SOURCES := $(wildcard logic/*.sv testbench/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
